// ==== src/uart_line_pkg.sv ====
`default_nettype none

package uart_line_pkg;

	// ========================================================================
	// Serial line side
	// ========================================================================

	// One received data byte
	typedef logic [7:0] byte_t;

	// Oversample ticks within one bit period
	typedef logic [3:0] sample_cnt_t;

	// Data bit position, LSB first
	typedef logic [2:0] bit_idx_t;

	typedef enum logic [1:0] {
		IDLE      = 2'b00,
		START_BIT = 2'b01,
		DATA_BITS = 2'b10,
		STOP_BIT  = 2'b11
	} rx_state_t;

	// Clock runs at this many ticks per bit
	localparam int OVERSAMPLE_DEFAULT = 16;

endpackage

`default_nettype wire

// ==== src/host_read_pkg.sv ====
`default_nettype none

package host_read_pkg;

	// ========================================================================
	// Host read side
	// ========================================================================

	// Byte replicated into four lanes
	typedef logic [31:0] word_t;

	// Saturating error count
	typedef logic [7:0] err_cnt_t;

	typedef enum logic [1:0] {
		IDLE    = 2'b00,
		POP     = 2'b01,
		CAPTURE = 2'b10,
		HOLD    = 2'b11
	} read_state_t;

endpackage

`default_nettype wire

// ==== src/uart_rx_sampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx_sampler #(
	parameter int OVERSAMPLE = uart_line_pkg::OVERSAMPLE_DEFAULT
) (
	input  wire                       baud_rx_clock,
	input  wire                       i_rst_n,
	input  wire                       i_rx,
	input  wire                       i_full,
	output logic                      o_wr_en,
	output uart_line_pkg::byte_t      o_wr_data,
	output logic                      o_overrun,
	output logic                      o_frame_err
);

	// Start bit is checked half a bit in, later bits a full bit apart
	localparam uart_line_pkg::sample_cnt_t MID_TICK =
		uart_line_pkg::sample_cnt_t'(OVERSAMPLE / 2 - 1);
	localparam uart_line_pkg::sample_cnt_t LAST_TICK =
		uart_line_pkg::sample_cnt_t'(OVERSAMPLE - 1);
	localparam uart_line_pkg::bit_idx_t LAST_BIT = 3'd7;

	uart_line_pkg::rx_state_t   state;
	uart_line_pkg::sample_cnt_t tick_cnt;
	uart_line_pkg::bit_idx_t    bit_idx;
	uart_line_pkg::byte_t       shift_reg;

	assign o_wr_data = shift_reg;

	// ========================================================================
	// Frame state machine
	// ========================================================================

	always_ff @(posedge baud_rx_clock) begin
		if (!i_rst_n) begin
			state       <= uart_line_pkg::IDLE;
			tick_cnt    <= '0;
			bit_idx     <= '0;
			o_wr_en     <= 1'b0;
			o_overrun   <= 1'b0;
			o_frame_err <= 1'b0;
		end else begin
			// Pulses last one cycle
			o_wr_en     <= 1'b0;
			o_overrun   <= 1'b0;
			o_frame_err <= 1'b0;

			case (state)
				uart_line_pkg::IDLE: begin
					tick_cnt <= '0;
					bit_idx  <= '0;
					if (i_rx == 1'b0) begin
						state <= uart_line_pkg::START_BIT;
					end
				end

				uart_line_pkg::START_BIT: begin
					if (tick_cnt == MID_TICK) begin
						tick_cnt <= '0;
						if (i_rx == 1'b0) begin
							state <= uart_line_pkg::DATA_BITS;
						end else begin
							// Too short for a start bit
							state <= uart_line_pkg::IDLE;
						end
					end else begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end

				uart_line_pkg::DATA_BITS: begin
					if (tick_cnt == LAST_TICK) begin
						tick_cnt <= '0;
						if (bit_idx == LAST_BIT) begin
							state <= uart_line_pkg::STOP_BIT;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end else begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end

				uart_line_pkg::STOP_BIT: begin
					if (tick_cnt == LAST_TICK) begin
						tick_cnt <= '0;
						state    <= uart_line_pkg::IDLE;
						if (i_rx == 1'b0) begin
							o_frame_err <= 1'b1;
						end else if (i_full) begin
							o_overrun <= 1'b1;
						end else begin
							o_wr_en <= 1'b1;
						end
					end else begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end

				default: begin
					state <= uart_line_pkg::IDLE;
				end
			endcase
		end
	end

	// Data path, LSB arrives first
	always_ff @(posedge baud_rx_clock) begin
		if (state == uart_line_pkg::DATA_BITS && tick_cnt == LAST_TICK) begin
			shift_reg <= {i_rx, shift_reg[7:1]};
		end
	end

endmodule

`default_nettype wire

// ==== src/rx_byte_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_byte_fifo #(
	parameter int FIFO_DEPTH = 32
) (
	input  wire                       baud_rx_clock,
	input  wire                       i_rst_n,
	input  wire                       i_wr_en,
	input  wire uart_line_pkg::byte_t i_wr_data,
	input  wire                       i_rd_en,
	output uart_line_pkg::byte_t      o_rd_data,
	output logic                      o_empty,
	output logic                      o_full
);

	localparam int ADDR_W = $clog2(FIFO_DEPTH);

	uart_line_pkg::byte_t mem [FIFO_DEPTH];

	// Extra MSB tells a full buffer from an empty one
	logic [ADDR_W:0] wr_ptr;
	logic [ADDR_W:0] rd_ptr;

	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
		(wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

	always_ff @(posedge baud_rx_clock) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (i_wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (i_rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Storage
	always_ff @(posedge baud_rx_clock) begin
		if (i_wr_en) begin
			mem[wr_ptr[ADDR_W-1:0]] <= i_wr_data;
		end
	end

	// Registered read, valid the cycle after the pop
	always_ff @(posedge baud_rx_clock) begin
		if (i_rd_en) begin
			o_rd_data <= mem[rd_ptr[ADDR_W-1:0]];
		end
	end

endmodule

`default_nettype wire

// ==== src/rx_read_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_read_port (
	input  wire                       baud_rx_clock,
	input  wire                       i_rst_n,
	input  wire                       i_enable,
	input  wire                       i_empty,
	input  wire uart_line_pkg::byte_t i_rd_data,
	input  wire                       i_overrun,
	input  wire                       i_frame_err,
	output logic                      o_rd_en,
	output host_read_pkg::word_t      o_rdata,
	output logic                      o_ready,
	output logic                      o_waiting,
	output host_read_pkg::err_cnt_t   o_overrun_count,
	output host_read_pkg::err_cnt_t   o_frame_err_count
);

	host_read_pkg::read_state_t state;

	// Counters stick at all ones
	function automatic host_read_pkg::err_cnt_t sat_inc(input host_read_pkg::err_cnt_t cnt);
		if (&cnt) begin
			return cnt;
		end
		return cnt + 1'b1;
	endfunction

	// ========================================================================
	// Host request sequencer
	// ========================================================================

	always_ff @(posedge baud_rx_clock) begin
		if (!i_rst_n) begin
			state     <= host_read_pkg::IDLE;
			o_rd_en   <= 1'b0;
			o_rdata   <= '0;
			o_ready   <= 1'b0;
			o_waiting <= 1'b0;
		end else begin
			o_rd_en <= 1'b0;
			if (!i_enable) begin
				state     <= host_read_pkg::IDLE;
				o_ready   <= 1'b0;
				o_waiting <= i_empty;
			end else begin
				case (state)
					host_read_pkg::IDLE: begin
						o_waiting <= i_empty;
						if (!i_empty) begin
							o_rd_en <= 1'b1;
							state   <= host_read_pkg::POP;
						end
					end

					// FIFO latches the byte on this edge
					host_read_pkg::POP: begin
						state <= host_read_pkg::CAPTURE;
					end

					host_read_pkg::CAPTURE: begin
						o_rdata <= {4{i_rd_data}};
						state   <= host_read_pkg::HOLD;
					end

					// Held until the host lets go of enable
					host_read_pkg::HOLD: begin
						o_ready <= 1'b1;
					end

					default: begin
						state <= host_read_pkg::IDLE;
					end
				endcase
			end
		end
	end

	// ========================================================================
	// Error counters
	// ========================================================================

	always_ff @(posedge baud_rx_clock) begin
		if (!i_rst_n) begin
			o_overrun_count   <= '0;
			o_frame_err_count <= '0;
		end else begin
			if (i_overrun) begin
				o_overrun_count <= sat_inc(o_overrun_count);
			end
			if (i_frame_err) begin
				o_frame_err_count <= sat_inc(o_frame_err_count);
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
	parameter int FIFO_DEPTH = 32,
	parameter int OVERSAMPLE = uart_line_pkg::OVERSAMPLE_DEFAULT
) (
	input  wire                     baud_rx_clock,
	input  wire                     i_rst_n,
	input  wire                     i_rx,
	input  wire                     i_enable,
	output host_read_pkg::word_t    o_rdata,
	output logic                    o_ready,
	output logic                    o_waiting,
	output host_read_pkg::err_cnt_t o_overrun_count,
	output host_read_pkg::err_cnt_t o_frame_err_count
);

	logic                 wr_en;
	uart_line_pkg::byte_t wr_data;
	logic                 overrun;
	logic                 frame_err;
	logic                 rd_en;
	uart_line_pkg::byte_t rd_data;
	logic                 fifo_empty;
	logic                 fifo_full;

	uart_rx_sampler #(
		.OVERSAMPLE(OVERSAMPLE)
	) sampler0 (
		.baud_rx_clock(baud_rx_clock),
		.i_rst_n      (i_rst_n),
		.i_rx         (i_rx),
		.i_full       (fifo_full),
		.o_wr_en      (wr_en),
		.o_wr_data    (wr_data),
		.o_overrun    (overrun),
		.o_frame_err  (frame_err)
	);

	rx_byte_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) fifo0 (
		.baud_rx_clock(baud_rx_clock),
		.i_rst_n      (i_rst_n),
		.i_wr_en      (wr_en),
		.i_wr_data    (wr_data),
		.i_rd_en      (rd_en),
		.o_rd_data    (rd_data),
		.o_empty      (fifo_empty),
		.o_full       (fifo_full)
	);

	rx_read_port port0 (
		.baud_rx_clock    (baud_rx_clock),
		.i_rst_n          (i_rst_n),
		.i_enable         (i_enable),
		.i_empty          (fifo_empty),
		.i_rd_data        (rd_data),
		.i_overrun        (overrun),
		.i_frame_err      (frame_err),
		.o_rd_en          (rd_en),
		.o_rdata          (o_rdata),
		.o_ready          (o_ready),
		.o_waiting        (o_waiting),
		.o_overrun_count  (o_overrun_count),
		.o_frame_err_count(o_frame_err_count)
	);

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 8
) (
	output logic baud_rx_clock,
	output logic o_rst_n
);

	initial begin
		baud_rx_clock = 1'b0;
		forever #(PERIOD_NS / 2) baud_rx_clock = ~baud_rx_clock;
	end

	// Reset released on a falling edge, like every other input
	initial begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge baud_rx_clock);
		@(negedge baud_rx_clock);
		o_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tests/tb_uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_uart_rx;

	localparam int BIT_CLOCKS   = 16;
	localparam int READ_LIMIT   = 64;
	localparam int TOTAL_FRAMES = 59;
	// Ten bits of sixteen 100 ns clocks per frame, plus room for reads and gaps
	localparam int WATCHDOG_NS  = TOTAL_FRAMES * 10 * BIT_CLOCKS * 100 + 300000;

	logic                    baud_rx_clock;
	logic                    rst_n;
	logic                    rx_line;
	logic                    enable;
	host_read_pkg::word_t    rdata;
	logic                    ready;
	logic                    waiting;
	host_read_pkg::err_cnt_t overrun_count;
	host_read_pkg::err_cnt_t frame_err_count;

	logic [16:0] lfsr_state;
	int          exp_overruns;
	int          exp_frame_errs;

	tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(8)) clk0 (
		.baud_rx_clock(baud_rx_clock),
		.o_rst_n      (rst_n)
	);

	uart_rx #(.FIFO_DEPTH(32), .OVERSAMPLE(16)) dut0 (
		.baud_rx_clock    (baud_rx_clock),
		.i_rst_n          (rst_n),
		.i_rx             (rx_line),
		.i_enable         (enable),
		.o_rdata          (rdata),
		.o_ready          (ready),
		.o_waiting        (waiting),
		.o_overrun_count  (overrun_count),
		.o_frame_err_count(frame_err_count)
	);

	// ========================================================================
	// Helpers
	// ========================================================================

	task automatic abort_run();
		$display("Test failures found");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_value(input string test_name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s %s: expected 0x%08h, actual 0x%08h",
				test_name, what, expected, actual);
			abort_run();
		end
	endtask

	// Taps 17 and 14
	function automatic logic [16:0] lfsr_step(input logic [16:0] state);
		return {state[15:0], state[16] ^ state[13]};
	endfunction

	task automatic random_byte(output logic [7:0] value);
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value[i] = lfsr_state[0];
		end
	endtask

	// Host sees the byte in every lane
	function automatic logic [31:0] replicate_byte(input logic [7:0] value);
		return {value, value, value, value};
	endfunction

	task automatic send_frame(input logic [7:0] data, input logic stop_level);
		rx_line = 1'b0;
		repeat (BIT_CLOCKS) @(negedge baud_rx_clock);
		for (int i = 0; i < 8; i++) begin
			rx_line = data[i];
			repeat (BIT_CLOCKS) @(negedge baud_rx_clock);
		end
		rx_line = stop_level;
		repeat (BIT_CLOCKS) @(negedge baud_rx_clock);
		rx_line = 1'b1;
	endtask

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		while (!ready && cycles < READ_LIMIT) begin
			@(negedge baud_rx_clock);
			cycles++;
		end
		if (!ready) begin
			$display("Timeout: o_ready did not rise within %0d cycles of the request",
				READ_LIMIT);
			abort_run();
		end
	endtask

	task automatic read_byte(output host_read_pkg::word_t word, output logic seen_waiting);
		enable = 1'b1;
		@(negedge baud_rx_clock);
		wait_ready();
		word = rdata;
		seen_waiting = waiting;
		enable = 1'b0;
		@(negedge baud_rx_clock);
	endtask

	// FIFO must be empty again
	task automatic check_drained(input string test_name);
		enable = 1'b1;
		repeat (3) @(negedge baud_rx_clock);
		check_value(test_name, "o_waiting", 32'd1, 32'(waiting));
		check_value(test_name, "o_ready", 32'd0, 32'(ready));
		enable = 1'b0;
		@(negedge baud_rx_clock);
	endtask

	task automatic stream_bytes(input string test_name, input int sent_count, input int kept);
		logic [7:0]           sent [$];
		logic [7:0]           value;
		host_read_pkg::word_t word;
		logic                 seen_waiting;
		for (int n = 0; n < sent_count; n++) begin
			random_byte(value);
			if (n < kept) begin
				sent.push_back(value);
			end
			send_frame(value, 1'b1);
		end
		while (sent.size() > 0) begin
			value = sent.pop_front();
			read_byte(word, seen_waiting);
			check_value(test_name, "o_rdata", replicate_byte(value), word);
			check_value(test_name, "o_waiting", 32'd0, 32'(seen_waiting));
		end
		check_drained(test_name);
	endtask

	// ========================================================================
	// Directed tests
	// ========================================================================

	task automatic test_idle_waiting();
		enable = 1'b1;
		repeat (2) @(negedge baud_rx_clock);
		repeat (50) begin
			check_value("test_idle_waiting", "o_waiting", 32'd1, 32'(waiting));
			check_value("test_idle_waiting", "o_ready", 32'd0, 32'(ready));
			@(negedge baud_rx_clock);
		end
		enable = 1'b0;
		@(negedge baud_rx_clock);
	endtask

	task automatic test_single_byte();
		host_read_pkg::word_t word;
		logic                 seen_waiting;
		send_frame(8'hA5, 1'b1);
		read_byte(word, seen_waiting);
		check_value("test_single_byte", "o_rdata", 32'hA5A5A5A5, word);
		check_value("test_single_byte", "o_waiting", 32'd0, 32'(seen_waiting));
	endtask

	task automatic test_framing_error();
		host_read_pkg::word_t word;
		logic                 seen_waiting;
		send_frame(8'h3C, 1'b0);
		// Idle line lets the sampler drop the stray start after the bad stop bit
		repeat (2 * BIT_CLOCKS) @(negedge baud_rx_clock);
		send_frame(8'h96, 1'b1);
		exp_frame_errs++;
		check_value("test_framing_error", "o_frame_err_count",
			32'(exp_frame_errs), 32'(frame_err_count));
		read_byte(word, seen_waiting);
		check_value("test_framing_error", "o_rdata", replicate_byte(8'h96), word);
		check_value("test_framing_error", "o_waiting", 32'd0, 32'(seen_waiting));
		check_drained("test_framing_error");
	endtask

	task automatic test_overrun();
		stream_bytes("test_overrun", 34, 32);
		exp_overruns += 2;
		check_value("test_overrun", "o_overrun_count", 32'(exp_overruns), 32'(overrun_count));
	endtask

	task automatic test_enable_release();
		logic [7:0]           first;
		logic [7:0]           second;
		host_read_pkg::word_t word;
		logic                 seen_waiting;
		random_byte(first);
		random_byte(second);
		send_frame(first, 1'b1);
		send_frame(second, 1'b1);
		enable = 1'b1;
		@(negedge baud_rx_clock);
		wait_ready();
		// Second byte stays queued while enable is held
		repeat (40) begin
			check_value("test_enable_release", "o_ready", 32'd1, 32'(ready));
			check_value("test_enable_release", "o_rdata", replicate_byte(first), rdata);
			@(negedge baud_rx_clock);
		end
		enable = 1'b0;
		@(negedge baud_rx_clock);
		check_value("test_enable_release", "o_ready after release", 32'd0, 32'(ready));
		read_byte(word, seen_waiting);
		check_value("test_enable_release", "o_rdata", replicate_byte(second), word);
		check_value("test_enable_release", "o_waiting", 32'd0, 32'(seen_waiting));
		check_drained("test_enable_release");
	endtask

	// ========================================================================
	// Sequence and watchdog
	// ========================================================================

	initial begin
		rx_line = 1'b1;
		enable = 1'b0;
		lfsr_state = 17'd95045;
		exp_overruns = 0;
		exp_frame_errs = 0;
		wait (rst_n == 1'b1);
		@(negedge baud_rx_clock);
		test_idle_waiting();
		test_single_byte();
		stream_bytes("test_random_stream", 20, 20);
		test_framing_error();
		test_overrun();
		test_enable_release();
		$display("All tests passed!");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		abort_run();
	end

endmodule

`default_nettype wire

// ==== uart_rx.f ====
src/uart_line_pkg.sv
src/host_read_pkg.sv
src/uart_rx_sampler.sv
src/rx_byte_fifo.sv
src/rx_read_port.sv
src/uart_rx.sv
tests/tb_clock_gen.sv
tests/tb_uart_rx.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UART receiver testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --top-module tb_uart_rx -f uart_rx.f -o tb_uart_rx

# The log decides the result, so a non-zero exit from the run is tolerated here
./obj_dir/tb_uart_rx > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
	echo "Simulation FAILED, see $LOG"
	exit 1
fi

echo "Simulation passed"
